// File: logic/webp_pkg.sv
// One 4x4 luma block per macroblock, DC prediction only; frame width at most MAX_MB_W - 1
`default_nettype none

package webp_pkg;

    // ------------------------------
    // Frame limits
    // ------------------------------
    localparam int MAX_MB_W   = 64;
    localparam int MB_COORD_W = 6;
    localparam int MB_SIZE    = 4;
    localparam int MB_PIXELS  = MB_SIZE * MB_SIZE;

    // Boundary values outside the frame
    localparam logic [7:0] TOP_DEFAULT  = 8'd127;
    localparam logic [7:0] LEFT_DEFAULT = 8'd129;

    // ------------------------------
    // Scalar types
    // ------------------------------
    typedef logic [7:0]            pixel_t;
    typedef logic signed [8:0]     level_t;
    typedef logic [MB_COORD_W-1:0] mb_coord_t;

    // ------------------------------
    // Structs
    // ------------------------------

    // p[0] is the top-left pixel, raster order
    typedef struct packed {
        pixel_t [MB_PIXELS-1:0] p;
    } mb_pixels_t;

    // Top row left to right, or left column top to bottom
    typedef struct packed {
        pixel_t [MB_SIZE-1:0] p;
    } edge_t;

    // Rounding is half of one step of (1 << shift)
    typedef struct packed {
        logic [2:0] shift;
        logic [7:0] zthresh;
    } quant_t;

    typedef struct packed {
        mb_coord_t              x;
        mb_coord_t              y;
        pixel_t                 dc;
        level_t [MB_PIXELS-1:0] levels;
        logic [5:0]             nz;
    } mb_result_t;

endpackage

`default_nettype wire

// File: logic/mb_sequencer.sv
// mb_w and mb_h must be nonzero; one macroblock in flight, results leave in raster order
`default_nettype none

module mb_sequencer (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_w,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_h,
    input  wire logic                          pix_empty,
    input  wire logic                          out_full,
    input  wire logic                          dec_done,
    output logic                               pix_rd,
    output logic                               dec_start,
    output logic                               out_wr,
    output logic                               done,
    output logic [webp_pkg::MB_COORD_W-1:0]      mb_x,
    output logic [webp_pkg::MB_COORD_W-1:0]      mb_y
);

    import webp_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        RDEN,
        DSTART,
        WAIT,
        FULL,
        NEXT,
        DONE
    } state_t;

    state_t    state;
    state_t    state_nx;
    mb_coord_t last_x;
    mb_coord_t last_y;
    logic      last_mb;

    assign last_mb = (mb_x == last_x) && (mb_y == last_y);

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nx = INIT;
                end
            end
            INIT: begin
                state_nx = RDEN;
            end
            RDEN: begin
                if (!pix_empty) begin
                    state_nx = DSTART;
                end
            end
            DSTART: begin
                // Hold here if the FIFO flag drops back
                if (!pix_empty) begin
                    state_nx = WAIT;
                end
            end
            WAIT: begin
                if (dec_done) begin
                    if (out_full) begin
                        state_nx = FULL;
                    end else begin
                        state_nx = last_mb ? DONE : NEXT;
                    end
                end
            end
            FULL: begin
                if (!out_full) begin
                    state_nx = last_mb ? DONE : NEXT;
                end
            end
            NEXT: begin
                state_nx = RDEN;
            end
            DONE: begin
                state_nx = IDLE;
            end
            default: begin
                state_nx = IDLE;
            end
        endcase
    end

    // ------------------------------
    // Strobes
    // ------------------------------
    // Pop and decimate start share one cycle, decimator latches the show-ahead word
    assign dec_start = (state == DSTART) && !pix_empty;
    assign pix_rd    = dec_start;

    // Write on the transition out of WAIT or FULL
    assign out_wr = !out_full && (((state == WAIT) && dec_done) || (state == FULL));
    assign done   = (state == DONE);

    // ------------------------------
    // Raster position
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb_x   <= '0;
            mb_y   <= '0;
            last_x <= '0;
            last_y <= '0;
        end else begin
            case (state)
                INIT: begin
                    mb_x   <= '0;
                    mb_y   <= '0;
                    last_x <= mb_w - 1'b1;
                    last_y <= mb_h - 1'b1;
                end
                NEXT: begin
                    if (mb_x == last_x) begin
                        mb_x <= '0;
                        mb_y <= mb_y + 1'b1;
                    end else begin
                        mb_x <= mb_x + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/mb_decimate.sv
// Fixed 18-cycle latency per block; quant reload honoured only while idle
`default_nettype none

module mb_decimate (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start,
    input  wire logic                          reload,
    input  wire webp_pkg::quant_t              quant,
    input  wire webp_pkg::mb_pixels_t          pix_data,
    input  wire webp_pkg::edge_t               top,
    input  wire webp_pkg::edge_t               left,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_x,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_y,
    output logic                               busy_done,
    output webp_pkg::mb_result_t               result,
    output webp_pkg::mb_pixels_t               recon
);

    import webp_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_PRED,
        D_PIX,
        D_FIN
    } dstate_t;

    dstate_t           state;
    logic [3:0]        idx;
    quant_t            quant_q;
    mb_pixels_t        pix_q;

    logic [10:0]       edge_sum;
    pixel_t            cur_pix;
    logic signed [9:0] resid;
    logic [8:0]        mag;
    logic [8:0]        half_step;
    logic              is_zero;
    logic [9:0]        q_mag;
    level_t            level;
    logic [10:0]       deq;
    logic signed [11:0] rec_full;
    pixel_t            rec_pix;

    // ------------------------------
    // DC prediction
    // ------------------------------
    always_comb begin
        edge_sum = 11'd4;
        for (int i = 0; i < MB_SIZE; i++) begin
            edge_sum = edge_sum + top.p[i] + left.p[i];
        end
    end

    // ------------------------------
    // Per-pixel quantise and rebuild
    // ------------------------------
    assign cur_pix   = pix_q.p[idx];
    assign resid     = $signed({2'b00, cur_pix}) - $signed({2'b00, result.dc});
    assign mag       = resid[9] ? 9'(-resid) : 9'(resid);
    assign half_step = (9'd1 << quant_q.shift) >> 1;
    assign is_zero   = mag <= {1'b0, quant_q.zthresh};
    assign q_mag     = is_zero ? 10'd0 : (({1'b0, mag} + {1'b0, half_step}) >> quant_q.shift);
    assign level     = resid[9] ? -$signed(q_mag[8:0]) : $signed(q_mag[8:0]);
    assign deq       = {1'b0, q_mag} << quant_q.shift;

    always_comb begin
        if (resid[9]) begin
            rec_full = $signed({4'd0, result.dc}) - $signed({1'b0, deq});
        end else begin
            rec_full = $signed({4'd0, result.dc}) + $signed({1'b0, deq});
        end
        if (rec_full[11]) begin
            rec_pix = 8'd0;
        end else if (rec_full > 12'sd255) begin
            rec_pix = 8'd255;
        end else begin
            rec_pix = rec_full[7:0];
        end
    end

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= D_IDLE;
            idx     <= '0;
            quant_q <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (start) begin
                        state <= D_PRED;
                    end else if (reload) begin
                        quant_q <= quant;
                    end
                end
                D_PRED: begin
                    idx   <= '0;
                    state <= D_PIX;
                end
                D_PIX: begin
                    idx <= idx + 1'b1;
                    if (idx == 4'(MB_PIXELS - 1)) begin
                        state <= D_FIN;
                    end
                end
                default: begin
                    state <= D_IDLE;
                end
            endcase
        end
    end

    assign busy_done = (state == D_FIN);

    // Result and recon hold from D_FIN until the next start
    always_ff @(posedge clk) begin
        case (state)
            D_IDLE: begin
                if (start) begin
                    pix_q    <= pix_data;
                    result.x <= mb_x;
                    result.y <= mb_y;
                end
            end
            D_PRED: begin
                result.dc <= edge_sum[10:3];
                result.nz <= '0;
            end
            D_PIX: begin
                result.levels[idx] <= level;
                recon.p[idx]       <= rec_pix;
                result.nz          <= result.nz + 6'(level != 9'sd0);
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/boundary_store.sv
// Edge defaults come from mb_x/mb_y being zero, so the line buffer is never cleared
`default_nettype none

module boundary_store (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          capture,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_x,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_y,
    input  wire webp_pkg::mb_pixels_t          recon,
    output webp_pkg::edge_t                    top,
    output webp_pkg::edge_t                    left
);

    import webp_pkg::*;

    edge_t line_mem [MAX_MB_W];
    edge_t left_q;
    edge_t bottom_row;
    edge_t right_col;

    // ------------------------------
    // Edge extraction
    // ------------------------------
    always_comb begin
        for (int i = 0; i < MB_SIZE; i++) begin
            bottom_row.p[i] = recon.p[(MB_SIZE - 1) * MB_SIZE + i];
            right_col.p[i]  = recon.p[i * MB_SIZE + MB_SIZE - 1];
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    // Bottom row per column, read back one frame row later
    always_ff @(posedge clk) begin
        if (capture) begin
            line_mem[mb_x] <= bottom_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= {MB_SIZE{LEFT_DEFAULT}};
        end else if (capture) begin
            left_q <= right_col;
        end
    end

    // ------------------------------
    // Neighbour selection
    // ------------------------------
    assign top  = (mb_y == '0) ? edge_t'({MB_SIZE{TOP_DEFAULT}}) : line_mem[mb_x];
    assign left = (mb_x == '0) ? edge_t'({MB_SIZE{LEFT_DEFAULT}}) : left_q;

endmodule

`default_nettype wire

// File: logic/webp_encode_top.sv
// Input FIFO must be show-ahead; quant and reload are only valid while no frame is running
`default_nettype none

module webp_encode_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_w,
    input  wire logic [webp_pkg::MB_COORD_W-1:0] mb_h,
    input  wire webp_pkg::quant_t              quant,
    input  wire logic                          reload,
    input  wire webp_pkg::mb_pixels_t          pix_data,
    input  wire logic                          pix_empty,
    output logic                               pix_rd,
    output webp_pkg::mb_result_t               out_data,
    output logic                               out_wr,
    input  wire logic                          out_full,
    output logic                               done
);

    import webp_pkg::*;

    logic       dec_start;
    logic       dec_done;
    mb_coord_t  mb_x;
    mb_coord_t  mb_y;
    mb_pixels_t recon;
    edge_t      top;
    edge_t      left;

    mb_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .mb_w      (mb_w),
        .mb_h      (mb_h),
        .pix_empty (pix_empty),
        .out_full  (out_full),
        .dec_done  (dec_done),
        .pix_rd    (pix_rd),
        .dec_start (dec_start),
        .out_wr    (out_wr),
        .done      (done),
        .mb_x      (mb_x),
        .mb_y      (mb_y)
    );

    mb_decimate u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (dec_start),
        .reload    (reload),
        .quant     (quant),
        .pix_data  (pix_data),
        .top       (top),
        .left      (left),
        .mb_x      (mb_x),
        .mb_y      (mb_y),
        .busy_done (dec_done),
        .result    (out_data),
        .recon     (recon)
    );

    // Captures on dec_done while mb_x/mb_y still name the finished block
    boundary_store u_bnd (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (dec_done),
        .mb_x    (mb_x),
        .mb_y    (mb_y),
        .recon   (recon),
        .top     (top),
        .left    (left)
    );

endmodule

`default_nettype wire

// File: tb/webp_encode_chk.sv
// Strobe protocol only; result values are checked against the model in the testbench
`default_nettype none

module webp_encode_chk (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic pix_rd,
    input wire logic pix_empty,
    input wire logic out_wr,
    input wire logic out_full,
    input wire logic done,
    input wire logic dec_start,
    input wire logic dec_done
);

    int   fail_count = 0;
    logic in_flight;

    // Block accepted by the decimator and not yet finished
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (dec_start) begin
            in_flight <= 1'b1;
        end else if (dec_done) begin
            in_flight <= 1'b0;
        end
    end

    rd_needs_data: assert property (@(posedge clk) disable iff (!rst_n) pix_rd |-> !pix_empty)
        else begin
            fail_count++;
            $error("pix_rd issued with the input FIFO empty");
        end

    wr_needs_room: assert property (@(posedge clk) disable iff (!rst_n) out_wr |-> !out_full)
        else begin
            fail_count++;
            $error("out_wr issued with the output FIFO full");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n) dec_start |-> !in_flight)
        else begin
            fail_count++;
            $error("second dec_start before dec_done");
        end

endmodule

bind webp_encode_top webp_encode_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_rd    (pix_rd),
    .pix_empty (pix_empty),
    .out_wr    (out_wr),
    .out_full  (out_full),
    .done      (done),
    .dec_start (dec_start),
    .dec_done  (dec_done)
);

`default_nettype wire

// File: tb/webp_encode_tb.sv
// One frame per test; expected results come from a behavioural model of DC predict and quantise
`default_nettype none

module webp_encode_tb;

    import webp_pkg::*;

    localparam int TOTAL_MBS      = 36;
    localparam int TIMEOUT_CYCLES = 30 * TOTAL_MBS + 2000;

    logic       clk;
    logic       rst_n;
    logic       start;
    mb_coord_t  mb_w;
    mb_coord_t  mb_h;
    quant_t     quant;
    logic       reload;
    mb_pixels_t pix_data;
    logic       pix_empty;
    logic       pix_rd;
    mb_result_t out_data;
    logic       out_wr;
    logic       out_full;
    logic       done;

    mb_pixels_t pix_fifo [$];
    mb_pixels_t frame_pix [$];
    mb_result_t exp_q [$];
    edge_t      model_top [MAX_MB_W];
    edge_t      model_left;

    logic [31:0] lcg_state = 32'h1c4b;
    int          shift_cur;
    int          zthresh_cur;
    bit          full_en;
    bit          empty_en;
    int          err_count;
    int          test_count;
    int          pass_count;
    int          frame_writes;
    int          frame_total;
    int          done_count;
    int          mon_cycle;
    int          last_wr_cycle;
    int          timeout_cycles;

    webp_encode_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .mb_w      (mb_w),
        .mb_h      (mb_h),
        .quant     (quant),
        .reload    (reload),
        .pix_data  (pix_data),
        .pix_empty (pix_empty),
        .pix_rd    (pix_rd),
        .out_data  (out_data),
        .out_wr    (out_wr),
        .out_full  (out_full),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_frame(input int w, input int h);
        mb_result_t res;
        mb_pixels_t pix;
        mb_pixels_t rec_blk;
        edge_t      top_e;
        edge_t      left_e;
        int         sum;
        int         dc;
        int         r;
        int         a;
        int         q;
        int         rec;
        int         nz;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                pix    = frame_pix[y * w + x];
                top_e  = (y == 0) ? edge_t'({4{TOP_DEFAULT}}) : model_top[x];
                left_e = (x == 0) ? edge_t'({4{LEFT_DEFAULT}}) : model_left;
                sum = 4;
                for (int i = 0; i < 4; i++) begin
                    sum = sum + int'(top_e.p[i]) + int'(left_e.p[i]);
                end
                dc     = sum >> 3;
                res.x  = 6'(x);
                res.y  = 6'(y);
                res.dc = 8'(dc);
                nz     = 0;
                for (int i = 0; i < 16; i++) begin
                    r = int'(pix.p[i]) - dc;
                    a = (r < 0) ? -r : r;
                    q = (a <= zthresh_cur) ? 0 : (a + ((1 << shift_cur) >> 1)) >> shift_cur;
                    nz = nz + ((q != 0) ? 1 : 0);
                    res.levels[i] = 9'((r < 0) ? -q : q);
                    rec = (r < 0) ? dc - (q << shift_cur) : dc + (q << shift_cur);
                    rec = (rec < 0) ? 0 : ((rec > 255) ? 255 : rec);
                    rec_blk.p[i] = 8'(rec);
                end
                res.nz = 6'(nz);
                for (int i = 0; i < 4; i++) begin
                    model_top[x].p[i] = rec_blk.p[12 + i];
                    model_left.p[i]   = rec_blk.p[i * 4 + 3];
                end
                exp_q.push_back(res);
            end
        end
    endtask

    task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            $display("Error: %s expected %h, got %h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic compare_result(input mb_result_t exp, input mb_result_t got);
        check_field("out_data.x", 16'(exp.x), 16'(got.x));
        check_field("out_data.y", 16'(exp.y), 16'(got.y));
        check_field("out_data.dc", 16'(exp.dc), 16'(got.dc));
        check_field("out_data.nz", 16'(exp.nz), 16'(got.nz));
        for (int i = 0; i < 16; i++) begin
            check_field($sformatf("out_data.levels[%0d]", i), 16'(exp.levels[i]),
                        16'(got.levels[i]));
        end
    endtask

    // ------------------------------
    // FIFO models and output monitor
    // ------------------------------
    always @(posedge clk) begin
        mon_cycle++;
        if (pix_rd) begin
            if (pix_fifo.size() == 0) begin
                $display("Read strobe while the input FIFO model holds no word");
                err_count++;
            end else begin
                void'(pix_fifo.pop_front());
            end
        end
        if (pix_fifo.size() != 0) begin
            pix_data <= pix_fifo[0];
        end
        pix_empty <= (pix_fifo.size() == 0) || (empty_en && (next_rand() < 32'h4000_0000));
        out_full  <= full_en && (next_rand() >= 32'h8000_0000);
        if (out_wr) begin
            if (exp_q.size() == 0) begin
                $display("Write at cycle %0d with no result pending", mon_cycle);
                err_count++;
            end else begin
                compare_result(exp_q.pop_front(), out_data);
            end
            frame_writes++;
            last_wr_cycle = mon_cycle;
        end
        if (done) begin
            done_count++;
            assert (mon_cycle == last_wr_cycle + 1 && frame_writes == frame_total) else begin
                $display("done did not follow the final write by one cycle");
                err_count++;
            end
        end
    end

    always @(posedge clk) begin
        timeout_cycles++;
        if (timeout_cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    task automatic load_quant(input int sh, input int zt);
        @(posedge clk);
        quant.shift   <= 3'(sh);
        quant.zthresh <= 8'(zt);
        reload        <= 1'b1;
        @(posedge clk);
        reload      <= 1'b0;
        shift_cur   = sh;
        zthresh_cur = zt;
    endtask

    task automatic run_frame(input string name, input int w, input int h, input bit flat,
                             input bit full_on, input bit empty_on);
        mb_pixels_t  pix;
        logic [31:0] rnd;
        int          errs_before;
        errs_before = err_count;
        @(negedge clk);
        frame_pix.delete();
        for (int n = 0; n < w * h; n++) begin
            for (int i = 0; i < 16; i++) begin
                rnd = next_rand();
                pix.p[i] = flat ? 8'd128 : rnd[23:16];
            end
            frame_pix.push_back(pix);
            pix_fifo.push_back(pix);
        end
        model_frame(w, h);
        full_en      = full_on;
        empty_en     = empty_on;
        frame_writes = 0;
        frame_total  = w * h;
        done_count   = 0;
        @(posedge clk);
        start <= 1'b1;
        mb_w  <= 6'(w);
        mb_h  <= 6'(h);
        @(posedge clk);
        start <= 1'b0;
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        assert (done_count == 1 && frame_writes == w * h && exp_q.size() == 0) else begin
            $display("Frame ended with %0d writes of %0d and %0d done pulses",
                     frame_writes, w * h, done_count);
            err_count++;
        end
        full_en  = 1'b0;
        empty_en = 1'b0;
        test_count++;
        if (err_count == errs_before) begin
            pass_count++;
        end
        $display("Test %0d %s: %s", test_count, name, (err_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int total_errors;
        rst_n     = 1'b0;
        start     = 1'b0;
        mb_w      = '0;
        mb_h      = '0;
        quant     = '0;
        reload    = 1'b0;
        pix_data  = '0;
        pix_empty = 1'b1;
        out_full  = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        load_quant(2, 1);
        run_frame("corner default 1x1", 1, 1, 1'b1, 1'b0, 1'b0);
        run_frame("raster and boundaries 3x2", 3, 2, 1'b0, 1'b0, 1'b0);
        run_frame("output back-pressure 4x2", 4, 2, 1'b0, 1'b1, 1'b0);
        run_frame("input stalls 3x3", 3, 3, 1'b0, 1'b0, 1'b1);
        run_frame("frame end, first 2x2", 2, 2, 1'b0, 1'b1, 1'b1);
        run_frame("frame end, second 2x2", 2, 2, 1'b0, 1'b1, 1'b1);
        load_quant(0, 0);
        run_frame("quantiser reload 2x2", 2, 2, 1'b0, 1'b1, 1'b1);
        total_errors = err_count + UUT.u_chk.fail_count;
        $display("Tests %0d, passed %0d, errors %0d", test_count, pass_count, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/webp_pkg.sv
logic/mb_sequencer.sv
logic/mb_decimate.sv
logic/boundary_store.sv
logic/webp_encode_top.sv
tb/webp_encode_chk.sv
tb/webp_encode_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; exit status follows the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module webp_encode_tb \
    -f build.f -o webp_encode_sim \
    && ./obj_dir/webp_encode_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -x "Simulation passed" > /dev/null \
    && echo "run_sim: PASS" && exit 0 \
    || { echo "run_sim: FAIL"; exit 1; }
